// File: alu.sv
/*
 * alu
 * add, sub, and, or, sll, sra plus compare and overflow flags
 */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module alu (
    input  logic [`CPU_XLEN-1:0] op_a,
    input  logic [`CPU_XLEN-1:0] op_b,
    input  cpu_pkg::alu_op_e     alu_op,
    input  logic [4:0]           shamt,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 not_equal,
    output logic                 less_than,
    output logic                 overflow
);

    localparam int msb = `CPU_XLEN - 1;

    logic [`CPU_XLEN-1:0] sum, diff;
    logic                 ovf_add, ovf_sub;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // signed overflow, operand signs vs result sign
    assign ovf_add = (op_a[msb] == op_b[msb]) && (sum[msb] != op_a[msb]);
    assign ovf_sub = (op_a[msb] != op_b[msb]) && (diff[msb] != op_a[msb]);

    // flags always from the subtraction, branches ignore alu_op
    assign not_equal = |diff;
    assign less_than = diff[msb] ^ ovf_sub;    // signed a < b

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add: result = sum;
            cpu_pkg::alu_sub: result = diff;
            cpu_pkg::alu_and: result = op_a & op_b;
            cpu_pkg::alu_or:  result = op_a | op_b;
            cpu_pkg::alu_sll: result = op_a << shamt;
            cpu_pkg::alu_sra: result = $signed(op_a) >>> shamt;    // sign fill
            default:          result = '0;
        endcase
        overflow = (alu_op == cpu_pkg::alu_add) ? ovf_add :
                   (alu_op == cpu_pkg::alu_sub) ? ovf_sub : 1'b0;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
cpu_pkg.sv
inst_decode.sv
reg_file.sv
alu.sv
bypass_unit.sv
execute_stage.sv
cpu_core.sv
tb_cpu_core.sv

// File: bypass_unit.sv
/*
 * bypass unit
 * picks the newest value of each execute operand from the memory
 * stage, the data memory for a load, or the writeback bus
 */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module bypass_unit (
    input  logic [`CPU_REG_ADDR_W-1:0] rs,
    input  logic [`CPU_REG_ADDR_W-1:0] rt,
    input  logic [`CPU_XLEN-1:0]       reg_a,
    input  logic [`CPU_XLEN-1:0]       reg_b,
    input  cpu_pkg::xm_reg_t           xm,
    input  logic [`CPU_XLEN-1:0]       load_data,
    input  cpu_pkg::wb_t               wb,
    output logic [`CPU_XLEN-1:0]       op_a,
    output logic [`CPU_XLEN-1:0]       op_b
);

    logic xm_is_lw;

    assign xm_is_lw = (xm.inst.opcode == cpu_pkg::op_lw);

    // memory stage first, then writeback, then the register file value
    function automatic logic [`CPU_XLEN-1:0] newest(
        input logic [`CPU_REG_ADDR_W-1:0] src,
        input logic [`CPU_XLEN-1:0]       reg_val
    );
        if (src == '0)
            return reg_val;                                  // r0 reads zero anyway
        if (xm.inst.reg_write && xm.inst.dest == src)
            return xm_is_lw ? load_data : xm.o;              // load data is live this cycle
        if (wb.reg_write && wb.dest == src)
            return wb.data;
        return reg_val;
    endfunction

    always_comb begin
        op_a = newest(rs, reg_a);
        op_b = newest(rt, reg_b);
    end

endmodule

`default_nettype wire

// File: cpu_cfg.svh
/*
 * cpu configuration
 * widths, special register numbers and exception codes shared by the core
 */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_XLEN        32      // data and address width
`define CPU_REG_ADDR_W  5       // register number width
`define CPU_REG_COUNT   32      // architectural registers, r0 included

// special registers
`define CPU_REG_RSTATUS 5'd30   // status, exceptions and setx land here
`define CPU_REG_RA      5'd31   // link register for jal

// overflow codes written into rstatus
`define CPU_EXC_ADD     1
`define CPU_EXC_ADDI    2
`define CPU_EXC_SUB     3

`endif

// File: cpu_core.sv
/*
 * cpu core
 * five-stage pipeline with pc, fetch/decode, decode/execute,
 * execute/memory and memory/writeback registers, taken branches and
 * jumps flush the two younger instructions
 */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu_core (
    input  logic                 clock,
    input  logic                 arst_n,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] imem_data,
    output cpu_pkg::dmem_req_t   dmem_req,
    input  logic [`CPU_XLEN-1:0] dmem_rdata
);

    logic [`CPU_XLEN-1:0] pc, pc_plus1;
    logic [`CPU_XLEN-1:0] reg_a, reg_b;          // register file read data
    logic [`CPU_XLEN-1:0] redirect_pc;
    logic                 redirect;

    cpu_pkg::fd_reg_t fd;
    cpu_pkg::dx_reg_t dx;
    cpu_pkg::xm_reg_t xm, xm_next;
    cpu_pkg::mw_reg_t mw;
    cpu_pkg::inst_t   dec;
    cpu_pkg::wb_t     wb;

    // fetch
    assign pc_plus1  = pc + 1;                   // word addressed
    assign imem_addr = pc;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            pc <= '0;
        else
            pc <= redirect ? redirect_pc : pc_plus1;
    end

    // fetch/decode and decode/execute, both squashed on a redirect
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fd <= '0;
            dx <= '0;
        end else if (redirect) begin
            fd <= '0;                            // two bubbles
            dx <= '0;
        end else begin
            fd <= '{pc_plus1: pc_plus1, inst: imem_data};
            dx <= '{pc_plus1: fd.pc_plus1, a: reg_a, b: reg_b, inst: dec};
        end
    end

    // decode
    inst_decode i_inst_decode (
        .inst (fd.inst),
        .dec  (dec)
    );

    reg_file i_reg_file (
        .clock  (clock),
        .arst_n (arst_n),
        .rs     (dec.rs),
        .rt     (dec.rt),
        .wb     (wb),
        .a      (reg_a),
        .b      (reg_b)
    );

    // execute
    execute_stage i_execute_stage (
        .dx          (dx),
        .xm          (xm),
        .load_data   (dmem_rdata),
        .wb          (wb),
        .xm_next     (xm_next),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // execute/memory and memory/writeback never stall
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            xm <= '0;
            mw <= '0;
        end else begin
            xm <= xm_next;
            mw <= '{o: xm.o, d: dmem_rdata, inst: xm.inst};
        end
    end

    // memory stage
    always_comb begin
        dmem_req.addr  = xm.o;
        dmem_req.wren  = (xm.inst.opcode == cpu_pkg::op_sw);
        dmem_req.wdata = xm.b;
        if (wb.reg_write && wb.dest == xm.inst.rt)
            dmem_req.wdata = wb.data;            // store data from writeback
    end

    // writeback
    always_comb begin
        wb.reg_write = mw.inst.reg_write;
        wb.dest      = mw.inst.dest;
        wb.data      = (mw.inst.opcode == cpu_pkg::op_lw) ? mw.d : mw.o;
    end

    a_wren_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown(dmem_req.wren))
        else $error("data memory write strobe unknown");

endmodule

`default_nettype wire

// File: cpu_pkg.sv
/*
 * cpu types
 * opcodes, alu operations, the decoded instruction and the pipeline registers
 */
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [4:0] {
        op_alu  = 5'd0,
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_jr   = 5'd4,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8,
        op_setx = 5'd21,
        op_bex  = 5'd22
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    // decoded once in decode, then carried down the pipe
    typedef struct packed {
        opcode_e                     opcode;
        alu_op_e                     alu_op;
        logic [4:0]                  shamt;
        logic [`CPU_REG_ADDR_W-1:0]  rs;        // port a source, 0 when unused
        logic [`CPU_REG_ADDR_W-1:0]  rt;        // port b source, 0 when unused
        logic [`CPU_REG_ADDR_W-1:0]  dest;
        logic                        reg_write;
        logic [`CPU_XLEN-1:0]        imm;       // sign extended
        logic [`CPU_XLEN-1:0]        target;    // zero extended
    } inst_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc_plus1;
        logic [`CPU_XLEN-1:0] inst;
    } fd_reg_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc_plus1;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
        inst_t                inst;
    } dx_reg_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] o;    // alu result or memory address
        logic [`CPU_XLEN-1:0] b;    // store data
        inst_t                inst;
    } xm_reg_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] o;
        logic [`CPU_XLEN-1:0] d;    // loaded word
        inst_t                inst;
    } mw_reg_t;

    typedef struct packed {
        logic                       reg_write;
        logic [`CPU_REG_ADDR_W-1:0] dest;
        logic [`CPU_XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
        logic                 wren;
    } dmem_req_t;

endpackage

`default_nettype wire

// File: execute_stage.sv
/*
 * execute stage
 * operand choice, branch and jump resolution, overflow exception
 * rewriting and the result that goes into the memory stage register
 */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module execute_stage (
    input  cpu_pkg::dx_reg_t     dx,
    input  cpu_pkg::xm_reg_t     xm,
    input  logic [`CPU_XLEN-1:0] load_data,
    input  cpu_pkg::wb_t         wb,
    output cpu_pkg::xm_reg_t     xm_next,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] redirect_pc
);

    logic [`CPU_XLEN-1:0] fwd_a, fwd_b;              // bypassed rs and rt values
    logic [`CPU_XLEN-1:0] alu_a, alu_b, alu_result;
    logic [`CPU_XLEN-1:0] exc_code;
    logic                 not_equal, less_than, overflow;
    logic                 is_branch, use_imm, exc_hit;
    cpu_pkg::opcode_e     op;

    assign op = dx.inst.opcode;

    bypass_unit i_bypass_unit (
        .rs        (dx.inst.rs),
        .rt        (dx.inst.rt),
        .reg_a     (dx.a),
        .reg_b     (dx.b),
        .xm        (xm),
        .load_data (load_data),
        .wb        (wb),
        .op_a      (fwd_a),
        .op_b      (fwd_b)
    );

    always_comb begin
        is_branch = (op == cpu_pkg::op_bne) || (op == cpu_pkg::op_blt);
        use_imm   = (op == cpu_pkg::op_addi) || (op == cpu_pkg::op_lw) || (op == cpu_pkg::op_sw);
        // branches compare rd (port b) against rs, so blt is rd < rs
        alu_a     = is_branch ? fwd_b : fwd_a;
        alu_b     = is_branch ? fwd_a : (use_imm ? dx.inst.imm : fwd_b);
    end

    alu i_alu (
        .op_a      (alu_a),
        .op_b      (alu_b),
        .alu_op    (dx.inst.alu_op),
        .shamt     (dx.inst.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than),
        .overflow  (overflow)
    );

    // redirect resolution
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = dx.pc_plus1 + dx.inst.imm;     // branch target, pc+1+N
        case (op)
            cpu_pkg::op_bne: redirect = not_equal;
            cpu_pkg::op_blt: redirect = less_than;
            cpu_pkg::op_j, cpu_pkg::op_jal: begin
                redirect    = 1'b1;
                redirect_pc = dx.inst.target;
            end
            cpu_pkg::op_bex: begin
                redirect    = (fwd_b != '0);         // rstatus set
                redirect_pc = dx.inst.target;
            end
            cpu_pkg::op_jr: begin
                redirect    = 1'b1;
                redirect_pc = fwd_a;
            end
            default: ;
        endcase
    end

    // result and exception rewrite
    always_comb begin
        exc_hit  = 1'b0;
        exc_code = '0;
        if (overflow && op == cpu_pkg::op_alu) begin
            exc_hit  = 1'b1;                         // alu only flags add and sub
            exc_code = (dx.inst.alu_op == cpu_pkg::alu_add) ? `CPU_EXC_ADD : `CPU_EXC_SUB;
        end else if (overflow && op == cpu_pkg::op_addi) begin
            exc_hit  = 1'b1;
            exc_code = `CPU_EXC_ADDI;
        end
        xm_next.inst = dx.inst;
        xm_next.b    = fwd_b;                        // store data for sw
        case (op)
            cpu_pkg::op_jal:  xm_next.o = dx.pc_plus1;
            cpu_pkg::op_setx: xm_next.o = dx.inst.imm;
            default:          xm_next.o = alu_result;
        endcase
        if (exc_hit) begin
            xm_next.o              = exc_code;       // code replaces the sum
            xm_next.inst.dest      = `CPU_REG_RSTATUS;
            xm_next.inst.reg_write = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: inst_decode.sv
/*
 * instruction decoder
 * splits a fetched word into its fields and derives destination,
 * write enable and the source registers each opcode actually reads
 */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module inst_decode (
    input  logic [`CPU_XLEN-1:0] inst,
    output cpu_pkg::inst_t       dec
);

    always_comb begin
        dec           = '0;                                  // unused sources stay at r0
        dec.opcode    = cpu_pkg::opcode_e'(inst[31:27]);
        dec.alu_op    = cpu_pkg::alu_add;                    // addi, lw, sw add
        dec.shamt     = inst[11:7];
        dec.imm       = {{(`CPU_XLEN-17){inst[16]}}, inst[16:0]};
        dec.target    = {{(`CPU_XLEN-27){1'b0}}, inst[26:0]};
        case (dec.opcode)
            cpu_pkg::op_alu: begin
                dec.rs        = inst[21:17];
                dec.rt        = inst[16:12];
                dec.dest      = inst[26:22];
                dec.reg_write = 1'b1;
                dec.alu_op    = cpu_pkg::alu_op_e'(inst[6:2]);
            end
            cpu_pkg::op_addi, cpu_pkg::op_lw: begin
                dec.rs        = inst[21:17];
                dec.dest      = inst[26:22];
                dec.reg_write = 1'b1;
            end
            cpu_pkg::op_sw, cpu_pkg::op_bne, cpu_pkg::op_blt: begin
                dec.rs = inst[21:17];
                dec.rt = inst[26:22];                        // rd comes in on port b
            end
            cpu_pkg::op_jal: begin
                dec.dest      = `CPU_REG_RA;
                dec.reg_write = 1'b1;
            end
            cpu_pkg::op_jr:   dec.rs = inst[26:22];          // jump register is rd
            cpu_pkg::op_setx: begin
                dec.dest      = `CPU_REG_RSTATUS;
                dec.reg_write = 1'b1;
                dec.imm       = dec.target;                  // value written is T
            end
            cpu_pkg::op_bex:  dec.rt = `CPU_REG_RSTATUS;     // tested against zero
            cpu_pkg::op_j:    ;                              // target only
            default:          ;                              // unknown opcode is a no-op
        endcase
        if (dec.dest == '0)
            dec.reg_write = 1'b0;                            // r0 never written
    end

endmodule

`default_nettype wire

// File: reg_file.sv
/*
 * register file
 * 31 writable registers plus a hardwired zero with two read ports and one write port
 * a write of the current cycle shows through on the read ports
 */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module reg_file (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic [`CPU_REG_ADDR_W-1:0] rs,
    input  logic [`CPU_REG_ADDR_W-1:0] rt,
    input  cpu_pkg::wb_t               wb,
    output logic [`CPU_XLEN-1:0]       a,
    output logic [`CPU_XLEN-1:0]       b
);

    logic [`CPU_XLEN-1:0] regs [1:`CPU_REG_COUNT-1];    // no storage for r0

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `CPU_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wb.reg_write && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through so decode sees the writeback of this cycle
    always_comb begin
        a = '0;
        b = '0;
        if (rs != '0)
            a = (wb.reg_write && wb.dest == rs) ? wb.data : regs[rs];
        if (rt != '0)
            b = (wb.reg_write && wb.dest == rt) ? wb.data : regs[rt];
    end

    // decode and the exception rewrite never aim a write at r0
    a_no_r0_write: assert property (@(posedge clock) disable iff (!arst_n)
        wb.reg_write |-> (wb.dest != '0))
        else $error("write enable raised for register 0");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the cpu core testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_cpu_core -f build.f -o sim_cpu_core \
    && ./obj_dir/sim_cpu_core | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_cpu_programs.svh
/*
 * test program table for the cpu core testbench
 * each row holds a name, a program, preset data words and the ordered stores it must make
 */
`ifndef TB_CPU_PROGRAMS_SVH
`define TB_CPU_PROGRAMS_SVH

task automatic fill_table();
    // dependent alu chain with each result stored afterwards
    begin_test(0, "alu_chain");
    emit(imm_word(cpu_pkg::op_addi, 1, 0, 5));
    emit(imm_word(cpu_pkg::op_addi, 2, 0, 3));
    emit(alu_word(3, 1, 2, 0, cpu_pkg::alu_add));      // 8 with r2 from the memory stage
    emit(alu_word(4, 3, 2, 0, cpu_pkg::alu_sub));      // 5 with r2 from writeback
    emit(alu_word(5, 4, 3, 0, cpu_pkg::alu_or));       // 13
    emit(alu_word(6, 5, 4, 0, cpu_pkg::alu_and));      // 5
    emit(alu_word(7, 6, 0, 4, cpu_pkg::alu_sll));      // 80
    emit(alu_word(8, 0, 7, 0, cpu_pkg::alu_sub));      // -80
    emit(alu_word(9, 8, 0, 2, cpu_pkg::alu_sra));      // -20
    emit(imm_word(cpu_pkg::op_addi, 0, 0, 9));         // r0 stays zero
    emit(alu_word(10, 0, 9, 0, cpu_pkg::alu_add));
    emit(imm_word(cpu_pkg::op_sw, 3, 0, 0));
    emit(imm_word(cpu_pkg::op_sw, 4, 0, 1));
    emit(imm_word(cpu_pkg::op_sw, 5, 0, 2));
    emit(imm_word(cpu_pkg::op_sw, 6, 0, 3));
    emit(imm_word(cpu_pkg::op_sw, 7, 0, 4));
    emit(imm_word(cpu_pkg::op_sw, 8, 0, 5));
    emit(imm_word(cpu_pkg::op_sw, 9, 0, 6));
    emit(imm_word(cpu_pkg::op_sw, 10, 0, 7));
    emit(imm_word(cpu_pkg::op_sw, 0, 0, MARKER));
    expect_store(0, 32'd8);
    expect_store(1, 32'd5);
    expect_store(2, 32'd13);
    expect_store(3, 32'd5);
    expect_store(4, 32'd80);
    expect_store(5, 32'hffff_ffb0);
    expect_store(6, 32'hffff_ffec);
    expect_store(7, 32'hffff_ffec);
    expect_store(MARKER, 32'd0);

    // loads feeding adds and stores of fresh results
    begin_test(1, "load_store");
    preset(10, rnd[0]);
    preset(11, rnd[1]);
    emit(imm_word(cpu_pkg::op_lw, 1, 0, 10));
    emit(alu_word(2, 1, 1, 0, cpu_pkg::alu_add));      // load word straight from memory
    emit(imm_word(cpu_pkg::op_lw, 3, 0, 11));
    emit(alu_word(4, 3, 1, 0, cpu_pkg::alu_add));
    emit(imm_word(cpu_pkg::op_sw, 4, 0, 20));          // data written one instruction before
    emit(imm_word(cpu_pkg::op_sw, 2, 0, 21));
    emit(imm_word(cpu_pkg::op_lw, 5, 0, 20));
    emit(imm_word(cpu_pkg::op_sw, 5, 0, 22));
    emit(imm_word(cpu_pkg::op_sw, 0, 0, MARKER));
    expect_store(20, rnd[0] + rnd[1]);
    expect_store(21, rnd[0] + rnd[0]);
    expect_store(22, rnd[0] + rnd[1]);
    expect_store(MARKER, 32'd0);

    // branches with the poison value in r7
    begin_test(2, "branches");
    emit(imm_word(cpu_pkg::op_addi, 7, 0, -1));
    emit(imm_word(cpu_pkg::op_addi, 1, 0, 1));
    emit(imm_word(cpu_pkg::op_addi, 2, 0, 2));
    emit(imm_word(cpu_pkg::op_bne, 1, 2, 2));          // taken to 6
    emit(imm_word(cpu_pkg::op_sw, 7, 0, 30));
    emit(imm_word(cpu_pkg::op_sw, 7, 0, 31));
    emit(imm_word(cpu_pkg::op_bne, 1, 1, 1));          // falls through
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 32));
    emit(imm_word(cpu_pkg::op_blt, 1, 2, 2));          // 1 < 2 so taken to 11
    emit(imm_word(cpu_pkg::op_sw, 7, 0, 33));
    emit(imm_word(cpu_pkg::op_sw, 7, 0, 34));
    emit(imm_word(cpu_pkg::op_blt, 2, 1, 1));          // falls through
    emit(imm_word(cpu_pkg::op_sw, 2, 0, 35));
    emit(imm_word(cpu_pkg::op_blt, 7, 1, 1));          // signed -1 < 1 so taken to 15
    emit(imm_word(cpu_pkg::op_sw, 7, 0, 36));
    emit(imm_word(cpu_pkg::op_sw, 0, 0, MARKER));
    expect_store(32, 32'd1);
    expect_store(35, 32'd2);
    expect_store(MARKER, 32'd0);

    // j, jal and jr through the link register
    begin_test(3, "jumps");
    emit(imm_word(cpu_pkg::op_addi, 1, 0, 7));
    emit(jump_word(cpu_pkg::op_j, 4));
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 40));
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 41));
    emit(jump_word(cpu_pkg::op_jal, 8));               // r31 = 5
    emit(imm_word(cpu_pkg::op_sw, 31, 0, 42));         // reached via jr
    emit(jump_word(cpu_pkg::op_j, 11));
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 43));
    emit(imm_word(cpu_pkg::op_sw, 31, 0, 44));
    emit(jump_word(cpu_pkg::op_jr, 31 << 22));         // rd field holds r31
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 45));
    emit(imm_word(cpu_pkg::op_sw, 0, 0, MARKER));
    expect_store(44, 32'd5);
    expect_store(42, 32'd5);
    expect_store(MARKER, 32'd0);

    // overflow codes in r30 then setx and bex
    begin_test(4, "exceptions");
    emit(imm_word(cpu_pkg::op_addi, 1, 0, 1));
    emit(alu_word(2, 1, 0, 30, cpu_pkg::alu_sll));     // 0x40000000
    emit(alu_word(3, 2, 2, 0, cpu_pkg::alu_add));      // overflow leaves code 1
    emit(imm_word(cpu_pkg::op_sw, 30, 0, 50));
    emit(alu_word(5, 1, 0, 31, cpu_pkg::alu_sll));     // 0x80000000
    emit(imm_word(cpu_pkg::op_addi, 6, 5, -1));        // overflow leaves code 2
    emit(imm_word(cpu_pkg::op_sw, 30, 0, 51));
    emit(alu_word(7, 5, 1, 0, cpu_pkg::alu_sub));      // overflow leaves code 3
    emit(imm_word(cpu_pkg::op_sw, 30, 0, 52));
    emit(imm_word(cpu_pkg::op_sw, 3, 0, 53));          // sum was never written
    emit(jump_word(cpu_pkg::op_setx, 0));
    emit(jump_word(cpu_pkg::op_bex, 14));              // r30 zero so it falls through
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 54));
    emit(jump_word(cpu_pkg::op_setx, 77));
    emit(jump_word(cpu_pkg::op_bex, 17));              // taken
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 55));
    emit(imm_word(cpu_pkg::op_sw, 1, 0, 56));
    emit(imm_word(cpu_pkg::op_sw, 30, 0, 57));
    emit(imm_word(cpu_pkg::op_sw, 0, 0, MARKER));
    expect_store(50, 32'd1);
    expect_store(51, 32'd2);
    expect_store(52, 32'd3);
    expect_store(53, 32'd0);
    expect_store(54, 32'd1);
    expect_store(57, 32'd77);
    expect_store(MARKER, 32'd0);
endtask

`endif

// File: tb_cpu_core.sv
/*
 * testbench for the pipelined cpu core
 * models both memories, runs each program of the table and checks its stores
 */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

    localparam int N_TESTS    = 5;
    localparam int MEM_WORDS  = 64;
    localparam int MAX_CYCLES = 400;
    localparam int MARKER     = 63;     // last store of every program
    localparam int MAX_EXP    = 9;

    logic               clock;
    logic               arst_n;
    logic [31:0]        imem_addr;
    logic [31:0]        imem_data;
    logic [31:0]        dmem_rdata;
    cpu_pkg::dmem_req_t dmem_req;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];

    // table filled from tb_cpu_programs.svh
    string       test_name [N_TESTS];
    logic [31:0] prog      [N_TESTS][MEM_WORDS];
    int          prog_len  [N_TESTS];
    int          exp_cnt   [N_TESTS];
    logic [31:0] exp_addr  [N_TESTS][MAX_EXP];
    logic [31:0] exp_data  [N_TESTS][MAX_EXP];
    int          pre_cnt   [N_TESTS];
    logic [31:0] pre_addr  [N_TESTS][4];
    logic [31:0] pre_data  [N_TESTS][4];
    logic [31:0] rnd       [2];         // random preset words of the load test
    logic [31:0] rnd_state;
    int          cur_t;
    int          passes;
    int          fails;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // instruction fields opcode[31:27] rd[26:22] rs[21:17] then rt or imm
    function automatic logic [31:0] alu_word(input int rd, input int rs, input int rt,
                                             input int shamt, input logic [4:0] aluop);
        return {5'd0, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], aluop, 2'b00};
    endfunction

    function automatic logic [31:0] imm_word(input logic [4:0] op, input int rd,
                                             input int rs, input int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] jump_word(input logic [4:0] op, input int target);
        return {op, target[26:0]};
    endfunction

    task automatic begin_test(input int t, input string name);
        cur_t          = t;
        test_name[t]   = name;
        prog_len[t]    = 0;
        exp_cnt[t]     = 0;
        pre_cnt[t]     = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            prog[t][i] = '0;                    // unused words run as no-ops
    endtask

    task automatic emit(input logic [31:0] word);
        prog[cur_t][prog_len[cur_t]] = word;
        prog_len[cur_t]++;
    endtask

    task automatic expect_store(input int addr, input logic [31:0] data);
        exp_addr[cur_t][exp_cnt[cur_t]] = addr;
        exp_data[cur_t][exp_cnt[cur_t]] = data;
        exp_cnt[cur_t]++;
    endtask

    task automatic preset(input int addr, input logic [31:0] data);
        pre_addr[cur_t][pre_cnt[cur_t]] = addr;
        pre_data[cur_t][pre_cnt[cur_t]] = data;
        pre_cnt[cur_t]++;
    endtask

    `include "tb_cpu_programs.svh"

    assign imem_data  = (imem_addr < MEM_WORDS) ? imem[imem_addr[5:0]] : '0;
    assign dmem_rdata = dmem[dmem_req.addr[5:0]];   // asynchronous read

    cpu_core i_cpu_core (
        .clock      (clock),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;              // 8 ns period
    end

    task automatic run_test(input int t);
        logic [31:0] got_addr [$];
        logic [31:0] got_data [$];
        int          cycles;
        bit          done;
        bit          ok;
        ok = 1'b1;
        @(negedge clock);
        arst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = prog[t][i];
            dmem[i] = 32'hd00d_0000 ^ (i * 32'h0101_0101);   // address-dependent fill
        end
        for (int i = 0; i < pre_cnt[t]; i++)
            dmem[pre_addr[t][i][5:0]] = pre_data[t][i];
        repeat (16) @(negedge clock);
        arst_n = 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < MAX_CYCLES) begin
            @(negedge clock);
            cycles++;
            if (dmem_req.wren) begin
                got_addr.push_back(dmem_req.addr);
                got_data.push_back(dmem_req.wdata);
                dmem[dmem_req.addr[5:0]] = dmem_req.wdata;   // lands before the commit edge
                if (dmem_req.addr == MARKER)
                    done = 1'b1;
            end
        end
        if (!done) begin
            $display("test %s timed out with no store to the marker address", test_name[t]);
            ok = 1'b0;
        end
        if (got_addr.size() != exp_cnt[t]) begin
            $display("ERR %s store count expected %0d actual %0d",
                     test_name[t], exp_cnt[t], got_addr.size());
            ok = 1'b0;
        end
        for (int i = 0; i < exp_cnt[t] && i < got_addr.size(); i++) begin
            if (got_addr[i] != exp_addr[t][i] || got_data[i] != exp_data[t][i]) begin
                $display("ERR %s store %0d expected [%0d]=%h actual [%0d]=%h", test_name[t],
                         i, exp_addr[t][i], exp_data[t][i], got_addr[i], got_data[i]);
                ok = 1'b0;
            end
        end
        if (ok) begin
            passes++;
            $display("test %s passed, %0d stores", test_name[t], got_addr.size());
        end else begin
            fails++;
            $display("test %s failed", test_name[t]);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        passes = 0;
        fails  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;                       // no-ops until the first program loads
            dmem[i] = 32'hd00d_0000 ^ (i * 32'h0101_0101);
        end
        rnd_state = xorshift(32'haecbad3f);
        rnd[0]    = rnd_state & 32'h3fff_ffff;  // below 2^30 so two words add without overflow
        rnd_state = xorshift(rnd_state);
        rnd[1]    = rnd_state & 32'h3fff_ffff;
        fill_table();
        for (int t = 0; t < N_TESTS; t++)
            run_test(t);
        $display("tests run %0d passed %0d failed %0d", N_TESTS, passes, fails);
        if (fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
